// File: pipe_cfg_pkg.sv
package pipe_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int NREGS      = 32;
    localparam int REG_AW     = $clog2(NREGS);

    localparam int LOAD_LAT   = 4;                          // cycles a load spends in EX.
    localparam int LAT_CW     = (LOAD_LAT > 2) ? $clog2(LOAD_LAT) : 1;

    localparam int DMEM_WORDS = 16;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);         // word index is addr[5:2].

    typedef enum logic [0:0] {
        RUN,
        WAIT_LOAD
    } ctrl_state_e;

    typedef struct packed {
        logic hold_id;                                      // freeze decode.
        logic hold_ex;                                      // freeze ID/EX.
    } stall_t;

endpackage

// File: cpu_types_pkg.sv
package cpu_types_pkg;

    import pipe_cfg_pkg::*;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NOP,                                            // must stay zero, bubbles are '0.
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_LOAD,
        ALU_STORE
    } alu_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;             // lw and sw.

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   op_a;                            // pc for auipc.
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   store_data;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic              we;
    } id_ex_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

// File: inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic [31:0]                     inst_i,
    input  logic [pipe_cfg_pkg::XLEN-1:0]   pc_i,
    input  logic                            inst_valid_i,
    input  logic [pipe_cfg_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [pipe_cfg_pkg::XLEN-1:0]   rs2_data_i,
    output logic [pipe_cfg_pkg::REG_AW-1:0] rs1_addr_o,
    output logic [pipe_cfg_pkg::REG_AW-1:0] rs2_addr_o,
    output cpu_types_pkg::id_ex_t           dec_o
);

    import pipe_cfg_pkg::*;
    import cpu_types_pkg::*;

    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_u;

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rd         = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        dec_o = '0;                                         // nop unless recognised.
        if (inst_valid_i) begin
            dec_o.pc = pc_i;
            dec_o.rd = rd;
            case (opcode)
                OPC_OP: begin
                    dec_o.op_a = rs1_data_i;
                    dec_o.op_b = rs2_data_i;
                    if (funct7 == F7_BASE) begin
                        case (funct3)
                            F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
                            F3_XOR:     dec_o.alu_op = ALU_XOR;
                            F3_OR:      dec_o.alu_op = ALU_OR;
                            F3_AND:     dec_o.alu_op = ALU_AND;
                            default:    dec_o.alu_op = ALU_NOP;
                        endcase
                    end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                        dec_o.alu_op = ALU_SUB;
                    end
                end
                OPC_OP_IMM: begin
                    if (funct3 == F3_ADD_SUB) begin             // addi only.
                        dec_o.alu_op = ALU_ADD;
                        dec_o.op_a   = rs1_data_i;
                        dec_o.op_b   = imm_i;
                        dec_o.imm    = imm_i;
                    end
                end
                OPC_AUIPC: begin
                    dec_o.alu_op = ALU_ADD;
                    dec_o.op_a   = pc_i;
                    dec_o.op_b   = imm_u;
                    dec_o.imm    = imm_u;
                end
                OPC_LOAD: begin
                    if (funct3 == F3_WORD) begin
                        dec_o.alu_op = ALU_LOAD;
                        dec_o.op_a   = rs1_data_i;
                        dec_o.imm    = imm_i;
                    end
                end
                OPC_STORE: begin
                    if (funct3 == F3_WORD) begin
                        dec_o.alu_op     = ALU_STORE;
                        dec_o.op_a       = rs1_data_i;
                        dec_o.store_data = rs2_data_i;
                        dec_o.imm        = imm_s;
                    end
                end
                default: dec_o.alu_op = ALU_NOP;
            endcase
            // only result-producing ops write, and never to x0
            dec_o.we = (dec_o.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                             ALU_LOAD}) && (rd != '0);
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [pipe_cfg_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [pipe_cfg_pkg::REG_AW-1:0] rs2_addr_i,
    input  cpu_types_pkg::wb_t              wb_i,
    output logic [pipe_cfg_pkg::XLEN-1:0]   rs1_data_o,
    output logic [pipe_cfg_pkg::XLEN-1:0]   rs2_data_o
);

    import pipe_cfg_pkg::*;

    logic [XLEN-1:0] regs_q [NREGS];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_i.we && wb_i.addr == addr) begin
            return wb_i.data;                               // write-first bypass.
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    // decode must already have dropped the write enable for rd = x0
    x0_never_written_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.we |-> (wb_i.addr != '0));

endmodule

// File: id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  cpu_types_pkg::id_ex_t dec_i,
    input  logic                  flush_i,
    input  pipe_cfg_pkg::stall_t  stall_i,
    input  logic                  load_done_i,
    output cpu_types_pkg::id_ex_t ex_o,
    output logic                  load_pending_o
);

    import cpu_types_pkg::*;

    logic dec_is_load;

    assign dec_is_load = (dec_i.alu_op == ALU_LOAD);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o           <= '0;
            load_pending_o <= 1'b0;
        end else if (flush_i) begin
            ex_o           <= '0;                           // drop whatever is in EX.
            load_pending_o <= 1'b0;
        end else if (load_done_i) begin
            ex_o           <= dec_i;                        // load retires, next one enters.
            load_pending_o <= dec_is_load;
        end else if (stall_i.hold_id && !stall_i.hold_ex) begin
            ex_o           <= '0;                           // bubble.
            load_pending_o <= 1'b0;
        end else if (!stall_i.hold_id) begin
            ex_o           <= dec_i;
            load_pending_o <= dec_is_load;
        end
    end

    // EX may only be frozen behind an outstanding load
    hold_ex_needs_load_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i.hold_ex |-> load_pending_o);

endmodule

// File: ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  cpu_types_pkg::id_ex_t ex_i,
    input  logic                  load_done_i,
    output cpu_types_pkg::wb_t    wb_o
);

    import pipe_cfg_pkg::*;
    import cpu_types_pkg::*;

    logic [XLEN-1:0]    dmem_q [DMEM_WORDS];
    logic [XLEN-1:0]    alu_res;
    logic [XLEN-1:0]    mem_addr;
    logic [DMEM_AW-1:0] word_idx;
    logic               is_load;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = ex_i.op_a + ex_i.op_b;
            ALU_SUB:    alu_res = ex_i.op_a - ex_i.op_b;
            ALU_AND:    alu_res = ex_i.op_a & ex_i.op_b;
            ALU_OR:     alu_res = ex_i.op_a | ex_i.op_b;
            ALU_XOR:    alu_res = ex_i.op_a ^ ex_i.op_b;
            ALU_PASS_B: alu_res = ex_i.op_b;
            default:    alu_res = '0;
        endcase
    end

    assign mem_addr = ex_i.op_a + ex_i.imm;
    assign word_idx = mem_addr[DMEM_AW+1:2];                // word aligned, low bits ignored.
    assign is_load  = (ex_i.alu_op == ALU_LOAD);

    always_ff @(posedge clk) begin
        if (ex_i.alu_op == ALU_STORE) begin
            dmem_q[word_idx] <= ex_i.store_data;
        end
    end

    always_comb begin
        wb_o.we   = ex_i.we && (!is_load || load_done_i);   // load only on its last cycle.
        wb_o.addr = ex_i.rd;
        wb_o.data = is_load ? dmem_q[word_idx] : alu_res;
    end

    // the timer and the ID/EX register must agree on what sits in EX
    done_only_for_load_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_done_i |-> is_load);

endmodule

// File: load_timer.sv
`timescale 1ns/1ps

module load_timer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic load_pending_i,
    input  logic flush_i,
    output logic load_done_o
);

    import pipe_cfg_pkg::*;

    logic [LAT_CW-1:0] cnt_q;
    logic              at_end;

    assign at_end      = (cnt_q == LAT_CW'(LOAD_LAT - 1));
    assign load_done_o = load_pending_i && at_end && !flush_i;  // flush aborts the load.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (flush_i || load_done_o || !load_pending_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // the count is only valid while the load stays pending until it completes or is flushed
    pending_held_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_pending_i && !load_done_o && !flush_i |=> load_pending_i);

endmodule

// File: pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 inst_valid_i,
    input  logic                 flush_i,
    input  logic                 load_pending_i,
    input  logic                 load_done_i,
    output pipe_cfg_pkg::stall_t stall_o,
    output logic                 fetch_stall_o
);

    import pipe_cfg_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        load_wait;

    assign load_wait = load_pending_i && !load_done_i;

    always_comb begin
        state_d = state_q;
        stall_o = '0;
        case (state_q)
            RUN: begin
                // first cycle of a load is still seen here
                stall_o.hold_ex = load_wait;
                stall_o.hold_id = load_wait || !inst_valid_i;   // invalid input gives a bubble.
                if (load_wait && !flush_i) begin
                    state_d = WAIT_LOAD;
                end
            end
            WAIT_LOAD: begin
                stall_o.hold_ex = !load_done_i;
                stall_o.hold_id = !load_done_i;
                if (load_done_i || flush_i) begin
                    state_d = RUN;
                end
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign fetch_stall_o = stall_o.hold_ex;                 // fetch must present the word again.

endmodule

// File: exec_pipe_top.sv
`timescale 1ns/1ps

module exec_pipe_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [31:0]                   inst_i,
    input  logic [pipe_cfg_pkg::XLEN-1:0] pc_i,
    input  logic                          inst_valid_i,
    input  logic                          flush_i,
    output logic                          stall_o,
    output cpu_types_pkg::wb_t            wb_o
);

    import pipe_cfg_pkg::*;
    import cpu_types_pkg::*;

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    id_ex_t            dec;
    id_ex_t            ex;
    stall_t            stall;
    logic              load_pending;
    logic              load_done;

    inst_decode u_inst_decode (
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_valid_i (inst_valid_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .dec_o        (dec)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dec_i          (dec),
        .flush_i        (flush_i),
        .stall_i        (stall),
        .load_done_i    (load_done),
        .ex_o           (ex),
        .load_pending_o (load_pending)
    );

    ex_unit u_ex_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex),
        .load_done_i (load_done),
        .wb_o        (wb_o)
    );

    load_timer u_load_timer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .load_pending_i (load_pending),
        .flush_i        (flush_i),
        .load_done_o    (load_done)
    );

    pipe_ctrl u_pipe_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .flush_i        (flush_i),
        .load_pending_i (load_pending),
        .load_done_i    (load_done),
        .stall_o        (stall),
        .fetch_stall_o  (stall_o)
    );

endmodule

// File: tb_exec_pipe.sv
`timescale 1ns/1ps

module tb_exec_pipe;

    import pipe_cfg_pkg::*;
    import cpu_types_pkg::*;

    localparam int N_RAND      = 40;
    localparam int N_DEP       = 8;
    localparam int N_AUIPC     = 6;
    localparam int N_MEM       = 6;                         // four words per store/load round.
    localparam int N_GAP       = 12;
    localparam int N_FLUSH     = 12;
    localparam int TOTAL_INSTS = N_RAND + N_DEP + N_AUIPC + 4 * N_MEM + N_GAP + N_FLUSH;
    localparam int MAX_CYCLES  = 40 * TOTAL_INSTS;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        inst_valid_i;
    logic        flush_i;
    logic        stall_o;
    wb_t         wb_o;

    integer      seed = 32'h3ad3;
    int          cyc;
    int          n_errors;
    int          n_checks;
    int          n_tests;
    int          errs_at_start;
    string       test_name = "reset";
    logic [31:0] next_pc;
    logic [31:0] sreg [32];                                 // shadow register file.
    logic [31:0] smem [16];                                 // shadow data memory.
    wb_t         exp_q [$];
    int          due_q [$];
    logic        load_busy;
    int          load_left;
    wb_t         pend_wb;

    exec_pipe_top dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_valid_i (inst_valid_i),
        .flush_i      (flush_i),
        .stall_o      (stall_o),
        .wb_o         (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] random_alu();
        logic [31:0] r;
        r = $random(seed);
        case (r[31:29])
            3'd0:    return r_type(F7_BASE, r[14:10], r[9:5], F3_ADD_SUB, r[4:0]);
            3'd1:    return r_type(F7_SUB, r[14:10], r[9:5], F3_ADD_SUB, r[4:0]);
            3'd2:    return r_type(F7_BASE, r[14:10], r[9:5], F3_AND, r[4:0]);
            3'd3:    return r_type(F7_BASE, r[14:10], r[9:5], F3_OR, r[4:0]);
            3'd4:    return r_type(F7_BASE, r[14:10], r[9:5], F3_XOR, r[4:0]);
            default: return i_type(r[26:15], r[9:5], F3_ADD_SUB, r[4:0], OPC_OP_IMM);
        endcase
    endfunction

    // executes one accepted word on the shadow state, stores land in smem here
    function automatic wb_t ref_exec(input logic [31:0] w, input logic [31:0] pc);
        wb_t         r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        r     = '0;
        a     = sreg[w[19:15]];
        b     = sreg[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        r.addr = w[11:7];
        case (w[6:0])
            OPC_OP: begin
                r.we = 1'b1;
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: r.data = a + b;
                    10'b0100000_000: r.data = a - b;
                    10'b0000000_100: r.data = a ^ b;
                    10'b0000000_110: r.data = a | b;
                    10'b0000000_111: r.data = a & b;
                    default:         r.we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                r.we   = (w[14:12] == 3'b000);
                r.data = a + imm_i;
            end
            OPC_AUIPC: begin
                r.we   = 1'b1;
                r.data = pc + {w[31:12], 12'b0};
            end
            OPC_LOAD: begin
                r.we   = (w[14:12] == 3'b010);
                r.data = smem[(a + imm_i) >> 2 & 32'hf];
            end
            OPC_STORE: begin
                if (w[14:12] == 3'b010) smem[(a + imm_s) >> 2 & 32'hf] = b;
            end
            default: r.we = 1'b0;
        endcase
        if (r.addr == 5'd0) r.we = 1'b0;                     // x0 stays zero.
        return r;
    endfunction

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: expected we=%0b x%0d=%08h, actual we=%0b x%0d=%08h",
                     name, exp.we, exp.addr, exp.data, act.we, act.addr, act.data);
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: stall_o expected %0b, actual %0b in cycle %0d",
                     name, exp, act, cyc);
        end
    endtask

    task automatic expect_wb(input wb_t rec, input int due);
        exp_q.push_back(rec);
        due_q.push_back(due);
        sreg[rec.addr] = rec.data;
    endtask

    // one clock of fetch: drive on the falling edge, decide 1 ns later
    task automatic step(input logic valid, input logic [31:0] word, input logic flush,
                        output logic taken);
        wb_t  rec;
        logic exp_stall;
        @(negedge clk);
        inst_valid_i = valid;
        inst_i       = valid ? word : $random(seed);         // junk while invalid.
        pc_i         = next_pc;
        flush_i      = flush;
        #1;
        exp_stall = load_busy && (load_left != 0 || flush);
        check_stall(test_name, exp_stall, stall_o);
        if (load_busy) begin
            if (flush) begin
                load_busy = 1'b0;                           // load aborted.
            end else if (load_left == 0) begin
                load_busy = 1'b0;
                if (pend_wb.we) expect_wb(pend_wb, cyc);
            end else begin
                load_left--;
            end
        end
        taken = valid && !stall_o;
        if (taken && !flush) begin
            rec = ref_exec(word, next_pc);
            if (word[6:0] == OPC_LOAD) begin
                load_busy = 1'b1;
                load_left = LOAD_LAT - 1;
                pend_wb   = rec;
            end else if (rec.we) begin
                expect_wb(rec, cyc + 1);
            end
        end
        if (taken) next_pc += 4;
    endtask

    task automatic issue(input logic [31:0] word);
        logic taken;
        taken = 1'b0;
        while (!taken) step(1'b1, word, 1'b0, taken);
    endtask

    task automatic idle();
        logic taken;
        step(1'b0, '0, 1'b0, taken);
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = n_errors;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0 || load_busy) idle();
        idle();
        n_tests++;
        $display("test %-12s %s", test_name, (n_errors == errs_at_start) ? "ok" : "had errors");
    endtask

    // the compare process, sampling late in each cycle
    initial begin
        wb_t exp;
        int  due;
        forever begin
            @(negedge clk);
            #2;
            if (rst_n_i && wb_o.we) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("unexpected writeback to x%0d in cycle %0d", wb_o.addr, cyc);
                end else begin
                    exp = exp_q.pop_front();
                    due = due_q.pop_front();
                    check_wb(test_name, exp, wb_o);
                    if (due != cyc) begin
                        n_errors++;
                        $display("writeback to x%0d came in cycle %0d, due in cycle %0d",
                                 wb_o.addr, cyc, due);
                    end
                end
            end else if (rst_n_i && due_q.size() != 0 && due_q[0] <= cyc) begin
                n_errors++;
                $display("writeback to x%0d missing in cycle %0d", exp_q[0].addr, cyc);
                exp = exp_q.pop_front();
                due = due_q.pop_front();
            end
        end
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc++;
            if (cyc > MAX_CYCLES) begin
                $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [11:0] off;
        logic        taken;
        rst_n_i      = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        inst_valid_i = 1'b0;
        flush_i      = 1'b0;
        next_pc      = 32'h0000_1000;
        load_busy    = 1'b0;
        load_left    = 0;
        pend_wb      = '0;
        n_errors     = 0;
        n_checks     = 0;
        n_tests      = 0;
        for (int i = 0; i < 32; i++) sreg[i] = '0;
        for (int i = 0; i < 16; i++) smem[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        begin_test("alu_random");
        for (int i = 0; i < N_RAND; i++) issue(random_alu());
        end_test();

        begin_test("dependency");
        issue(i_type(12'hfdb, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));  // negative immediate.
        issue(r_type(F7_BASE, 5'd5, 5'd5, F3_ADD_SUB, 5'd6));
        issue(r_type(F7_SUB, 5'd5, 5'd6, F3_ADD_SUB, 5'd7));
        issue(r_type(F7_BASE, 5'd6, 5'd7, F3_XOR, 5'd8));
        issue(i_type(12'h155, 5'd8, F3_ADD_SUB, 5'd0, OPC_OP_IMM));  // x0 target, no writeback.
        issue(r_type(F7_BASE, 5'd8, 5'd0, F3_ADD_SUB, 5'd9));
        issue(r_type(F7_BASE, 5'd0, 5'd9, F3_OR, 5'd10));
        issue(r_type(F7_BASE, 5'd6, 5'd10, F3_AND, 5'd5));
        end_test();

        begin_test("auipc");
        for (int i = 0; i < N_AUIPC; i++) begin
            r       = $random(seed);
            next_pc = {r[31:2], 2'b00};
            r       = $random(seed);
            issue({r[31:12], r[4:0], OPC_AUIPC});
        end
        end_test();

        begin_test("store_load");
        for (int i = 0; i < N_MEM; i++) begin
            r   = $random(seed);
            off = {6'b0, r[3:0], 2'b00};
            issue(i_type(r[27:16], 5'd0, F3_ADD_SUB, 5'd20, OPC_OP_IMM));
            issue(s_type(off, 5'd20, 5'd0));
            issue(i_type(off, 5'd0, F3_WORD, 5'd21, OPC_LOAD));
            issue(r_type(F7_BASE, 5'd20, 5'd21, F3_ADD_SUB, 5'd22));  // uses the loaded word.
        end
        end_test();

        begin_test("gaps");
        for (int i = 0; i < N_GAP; i++) begin
            issue(random_alu());
            r = $random(seed);
            repeat (r[1:0]) idle();
        end
        end_test();

        begin_test("flush");
        issue(i_type(12'd100, 5'd0, F3_ADD_SUB, 5'd13, OPC_OP_IMM));
        step(1'b1, i_type(12'd55, 5'd0, F3_ADD_SUB, 5'd14, OPC_OP_IMM), 1'b1, taken);
        issue(r_type(F7_BASE, 5'd13, 5'd14, F3_ADD_SUB, 5'd15));
        issue(s_type(12'd8, 5'd13, 5'd0));
        issue(i_type(12'd8, 5'd0, F3_WORD, 5'd16, OPC_LOAD));
        idle();
        step(1'b1, r_type(F7_BASE, 5'd13, 5'd16, F3_ADD_SUB, 5'd17), 1'b1, taken);
        issue(r_type(F7_BASE, 5'd13, 5'd16, F3_ADD_SUB, 5'd17));
        issue(i_type(12'd8, 5'd0, F3_WORD, 5'd18, OPC_LOAD));
        step(1'b1, i_type(12'd1, 5'd18, F3_ADD_SUB, 5'd19, OPC_OP_IMM), 1'b1, taken);
        issue(i_type(12'd1, 5'd18, F3_ADD_SUB, 5'd19, OPC_OP_IMM));
        issue(i_type(12'd8, 5'd0, F3_WORD, 5'd18, OPC_LOAD));
        issue(r_type(F7_BASE, 5'd18, 5'd18, F3_ADD_SUB, 5'd19));
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
pipe_cfg_pkg.sv
cpu_types_pkg.sv
inst_decode.sv
reg_file.sv
id_ex_reg.sv
ex_unit.sv
load_timer.sv
pipe_ctrl.sv
exec_pipe_top.sv
tb_exec_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the exec pipe testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_exec_pipe -o sim_exec_pipe
./obj_dir/sim_exec_pipe | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
grep -q "TEST PASS" sim.log
exit 0
